//--- hdl/memory_game_pkg.sv
// memory game shared definitions
// widths, timing constants, press and status records, controller states

package memory_game_pkg;

    // ------------------------------------------------------------------------
    // widths with a meaning
    // ------------------------------------------------------------------------
    // one bit per button, same layout drives the leds
    typedef logic [3:0]  button_t;
    // rom address or round index
    typedef logic [3:0]  addr_t;
    typedef logic [15:0] timer_t;

    // ------------------------------------------------------------------------
    // game constants
    // ------------------------------------------------------------------------
    localparam int unsigned EASY_ROUNDS = 8;
    localparam int unsigned HARD_ROUNDS = 16;

    // kept short so a full hard game simulates quickly
    localparam timer_t SHOW_CYCLES    = 16'd6;
    localparam timer_t GAP_CYCLES     = 16'd2;
    localparam timer_t TIMEOUT_CYCLES = 16'd200;

    // one player press, valid for a single cycle
    typedef struct packed {
        logic    valid;
        button_t code;
        logic    multi;
    } press_t;

    // outcome bits, done marks the end of a game
    typedef struct packed {
        logic won;
        logic lost;
        logic timed_out;
        logic done;
    } game_status_t;

    typedef enum logic [2:0] {
        idle,
        fetch,
        show_on,
        show_off,
        wait_play,
        check,
        next_round,
        finished
    } game_state_t;

endpackage

//--- hdl/play_capture.sv
// play capture
// registers the raw buttons and turns each new press into a one-cycle event,
// flagging presses with more than one button down

`timescale 1ns/1ps

module play_capture (
    input  logic                     clock,
    input  logic                     rst_n,
    input  memory_game_pkg::button_t buttons,
    output memory_game_pkg::press_t  press
);

    memory_game_pkg::button_t btn_q;
    memory_game_pkg::button_t code_q;
    logic                     released;
    logic                     valid_q;
    logic                     multi_q;
    logic                     new_press;

    // first non-zero sample after a full release
    assign new_press = released && (btn_q != '0);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            btn_q    <= '0;
            released <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            btn_q   <= buttons;
            valid_q <= new_press;
            // rearm only once every button is up
            if (btn_q == '0) begin
                released <= 1'b1;
            end else if (new_press) begin
                released <= 1'b0;
            end
        end
    end

    // press payload, taken with the event
    always_ff @(posedge clock) begin
        if (new_press) begin
            code_q  <= btn_q;
            multi_q <= |(btn_q & (btn_q - 1'b1));
        end
    end

    assign press.valid = valid_q;
    assign press.code  = code_q;
    assign press.multi = multi_q;

    a_press_single: assert property (@(posedge clock) disable iff (!rst_n)
        press.valid |=> !press.valid)
        else $error("press valid held for two cycles");

endmodule

//--- hdl/sequence_rom.sv
// sequence rom
// 16 x 4 pattern of button codes with a registered read,
// contents loaded from sequence.hex

`timescale 1ns/1ps

module sequence_rom (
    input  logic                     clock,
    input  memory_game_pkg::addr_t   addr,
    output memory_game_pkg::button_t data
);

    memory_game_pkg::button_t mem [0:15];

    initial begin
        $readmemh("sequence.hex", mem);
    end

    // data follows the address by one edge
    always_ff @(posedge clock) begin
        data <= mem[addr];
    end

endmodule

//--- hdl/game_controller.sv
// game controller
// plays back the sequence round by round, compares the player's presses
// against the rom, runs the press timeout and reports the outcome

`timescale 1ns/1ps

module game_controller (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic                          level,
    input  memory_game_pkg::press_t       press,
    output memory_game_pkg::addr_t        rom_addr,
    input  memory_game_pkg::button_t      rom_data,
    output memory_game_pkg::button_t      leds,
    output logic                          awaiting_play,
    output memory_game_pkg::game_status_t status
);

    memory_game_pkg::game_state_t  state;
    memory_game_pkg::game_state_t  state_next;
    memory_game_pkg::addr_t        round_cnt;
    memory_game_pkg::addr_t        last_round;
    memory_game_pkg::addr_t        addr;
    memory_game_pkg::timer_t       disp_cnt;
    memory_game_pkg::timer_t       tmo_cnt;
    memory_game_pkg::game_status_t status_q;
    memory_game_pkg::button_t      press_code;
    logic                          press_multi;
    logic                          awaiting_q;

    logic show_end;
    logic gap_end;
    logic disp_last;
    logic tmo_end;
    logic press_ok;
    logic last_press;

    // ------------------------------------------------------------------------
    // decisions
    // ------------------------------------------------------------------------
    assign show_end   = (disp_cnt == memory_game_pkg::SHOW_CYCLES - 16'd1);
    assign gap_end    = (disp_cnt == memory_game_pkg::GAP_CYCLES - 16'd1);
    // addr already moved past the last shown item
    assign disp_last  = (addr == memory_game_pkg::addr_t'(round_cnt + 4'd1));
    assign tmo_end    = (tmo_cnt == memory_game_pkg::TIMEOUT_CYCLES - 16'd1);
    assign press_ok   = !press_multi && (press_code == rom_data);
    assign last_press = (addr == round_cnt);

    always_comb begin
        state_next = state;
        unique case (state)
            memory_game_pkg::idle: begin
                if (start) state_next = memory_game_pkg::fetch;
            end
            memory_game_pkg::fetch: begin
                state_next = memory_game_pkg::show_on;
            end
            memory_game_pkg::show_on: begin
                if (show_end) state_next = memory_game_pkg::show_off;
            end
            memory_game_pkg::show_off: begin
                if (gap_end) begin
                    state_next = disp_last ? memory_game_pkg::wait_play
                                           : memory_game_pkg::show_on;
                end
            end
            memory_game_pkg::wait_play: begin
                // a press in the last cycle still counts
                if (press.valid) begin
                    state_next = memory_game_pkg::check;
                end else if (tmo_end) begin
                    state_next = memory_game_pkg::finished;
                end
            end
            memory_game_pkg::check: begin
                if (!press_ok) begin
                    state_next = memory_game_pkg::finished;
                end else if (last_press) begin
                    state_next = memory_game_pkg::next_round;
                end else begin
                    state_next = memory_game_pkg::wait_play;
                end
            end
            memory_game_pkg::next_round: begin
                state_next = (round_cnt == last_round) ? memory_game_pkg::finished
                                                       : memory_game_pkg::fetch;
            end
            memory_game_pkg::finished: begin
                if (start) state_next = memory_game_pkg::fetch;
            end
            default: state_next = memory_game_pkg::idle;
        endcase
    end

    // ------------------------------------------------------------------------
    // state, counters and outcome
    // ------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= memory_game_pkg::idle;
            round_cnt  <= '0;
            last_round <= '0;
            addr       <= '0;
            disp_cnt   <= '0;
            tmo_cnt    <= '0;
            status_q   <= '0;
            awaiting_q <= 1'b0;
        end else begin
            state      <= state_next;
            awaiting_q <= (state_next == memory_game_pkg::wait_play);
            unique case (state)
                memory_game_pkg::idle, memory_game_pkg::finished: begin
                    if (start) begin
                        round_cnt  <= '0;
                        addr       <= '0;
                        status_q   <= '0;
                        last_round <= level ? memory_game_pkg::addr_t'(memory_game_pkg::HARD_ROUNDS - 1)
                                            : memory_game_pkg::addr_t'(memory_game_pkg::EASY_ROUNDS - 1);
                    end
                end
                memory_game_pkg::fetch: begin
                    disp_cnt <= '0;
                end
                memory_game_pkg::show_on: begin
                    // next address goes out during the gap
                    if (show_end) begin
                        disp_cnt <= '0;
                        addr     <= addr + 4'd1;
                    end else begin
                        disp_cnt <= disp_cnt + 16'd1;
                    end
                end
                memory_game_pkg::show_off: begin
                    if (gap_end) begin
                        disp_cnt <= '0;
                        if (disp_last) begin
                            addr    <= '0;
                            tmo_cnt <= '0;
                        end
                    end else begin
                        disp_cnt <= disp_cnt + 16'd1;
                    end
                end
                memory_game_pkg::wait_play: begin
                    tmo_cnt <= tmo_cnt + 16'd1;
                    if (!press.valid && tmo_end) begin
                        status_q.timed_out <= 1'b1;
                        status_q.done      <= 1'b1;
                    end
                end
                memory_game_pkg::check: begin
                    if (!press_ok) begin
                        status_q.lost <= 1'b1;
                        status_q.done <= 1'b1;
                    end else if (!last_press) begin
                        addr    <= addr + 4'd1;
                        tmo_cnt <= '0;
                    end
                end
                memory_game_pkg::next_round: begin
                    if (round_cnt == last_round) begin
                        status_q.won  <= 1'b1;
                        status_q.done <= 1'b1;
                    end else begin
                        round_cnt <= round_cnt + 4'd1;
                        addr      <= '0;
                    end
                end
                default: ;
            endcase
        end
    end

    // press held for the check cycle
    always_ff @(posedge clock) begin
        if (state == memory_game_pkg::wait_play && press.valid) begin
            press_code  <= press.code;
            press_multi <= press.multi;
        end
    end

    assign rom_addr      = addr;
    assign leds          = (state == memory_game_pkg::show_on) ? rom_data : '0;
    assign awaiting_play = awaiting_q;
    assign status        = status_q;

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    a_one_outcome: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0({status.won, status.lost, status.timed_out}))
        else $error("more than one outcome bit set");

    a_awaiting_state: assert property (@(posedge clock) disable iff (!rst_n)
        awaiting_play |-> state == memory_game_pkg::wait_play)
        else $error("awaiting_play outside wait_play");

    a_done_outcome: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(status.done) |-> $onehot({status.won, status.lost, status.timed_out}))
        else $error("done without a single outcome");

endmodule

//--- hdl/memory_game.sv
// memory game top
// press capture, sequence rom and game controller joined together

`timescale 1ns/1ps

module memory_game (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic                          level,
    input  memory_game_pkg::button_t      buttons,
    output memory_game_pkg::button_t      leds,
    output logic                          awaiting_play,
    output memory_game_pkg::game_status_t status
);

    memory_game_pkg::press_t  press;
    memory_game_pkg::addr_t   rom_addr;
    memory_game_pkg::button_t rom_data;

    // ------------------------------------------------------------------------
    // player side
    // ------------------------------------------------------------------------
    play_capture capture_i (
        .clock   (clock),
        .rst_n   (rst_n),
        .buttons (buttons),
        .press   (press)
    );

    // pattern store
    sequence_rom rom_i (
        .clock (clock),
        .addr  (rom_addr),
        .data  (rom_data)
    );

    // ------------------------------------------------------------------------
    // game flow
    // ------------------------------------------------------------------------
    game_controller ctrl_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .start         (start),
        .level         (level),
        .press         (press),
        .rom_addr      (rom_addr),
        .rom_data      (rom_data),
        .leds          (leds),
        .awaiting_play (awaiting_play),
        .status        (status)
    );

endmodule

//--- testbench/memory_game_tb.sv
// memory game testbench
// plays easy and hard games to the end, loses games by a wrong or a multi
// button press, lets a press time out, and checks the led display order

`timescale 1ns/1ps

module memory_game_tb;

    // two hard games of display and presses fit well inside this
    localparam int MAX_CYCLES = 60000;
    // edges left after the press task before the outcome must show
    localparam int DONE_SLACK = 2;

    logic                          clock;
    logic                          rst_n;
    logic                          start;
    logic                          level;
    memory_game_pkg::button_t      buttons;
    memory_game_pkg::button_t      leds;
    logic                          awaiting_play;
    memory_game_pkg::game_status_t status;

    memory_game_pkg::button_t seq_mem [0:15];
    memory_game_pkg::button_t prev_leds;
    logic [31:0]              lfsr;
    string                    test_name;
    int                       mismatches;
    int                       failures;
    int                       cycle_cnt;
    int                       cur_round;
    int                       shown_cnt;
    int                       low_run;

    memory_game dut_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .start         (start),
        .level         (level),
        .buttons       (buttons),
        .leds          (leds),
        .awaiting_play (awaiting_play),
        .status        (status)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: no result after %0d cycles", MAX_CYCLES);
            $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // display monitor, values sampled before each edge
    // ------------------------------------------------------------------------
    always @(posedge clock) begin
        if (rst_n) begin
            if (leds != '0 && prev_leds == '0) begin
                assert (leds == seq_mem[shown_cnt]) else begin
                    $display("Mismatch %s display item %0d: expected %h, actual %h",
                             test_name, shown_cnt, seq_mem[shown_cnt], leds);
                    mismatches++;
                end
                shown_cnt++;
            end
            if (!awaiting_play) begin
                low_run++;
            end else begin
                // only the check cycle is a one cycle gap, longer means a display pass
                if (low_run > 1) begin
                    assert (shown_cnt == cur_round) else begin
                        $display("Mismatch %s items in round %0d: expected %0d, actual %0d",
                                 test_name, cur_round, cur_round, shown_cnt);
                        mismatches++;
                    end
                    shown_cnt = 0;
                end
                low_run = 0;
            end
        end
        prev_leds = leds;
    end

    a_reset_outputs: assert property (@(posedge clock)
        !rst_n |=> (leds == '0 && !awaiting_play && status == '0))
        else begin
            $display("Mismatch %s after reset: expected 0/0/0, actual %h/%b/%b",
                     test_name, leds, awaiting_play, status);
            mismatches++;
        end

    a_dark_while_waiting: assert property (@(posedge clock) disable iff (!rst_n)
        awaiting_play |-> leds == '0)
        else begin
            $display("Mismatch %s leds while awaiting play: expected 0, actual %h",
                     test_name, leds);
            mismatches++;
        end

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    // fibonacci lfsr x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = (val << 1) | int'(lfsr[0]);
        end
        return val;
    endfunction

    function automatic memory_game_pkg::button_t wrong_code(
        input memory_game_pkg::button_t good, input bit multi);
        memory_game_pkg::button_t other;
        other = 4'b0001 << take_bits(2);
        // rotate away from the right button
        if (other == good) other = {other[2:0], other[3]};
        return multi ? (good | other) : other;
    endfunction

    function automatic memory_game_pkg::game_status_t outcome(
        input logic won, input logic lost, input logic timed_out);
        memory_game_pkg::game_status_t s;
        s.won       = won;
        s.lost      = lost;
        s.timed_out = timed_out;
        s.done      = 1'b1;
        return s;
    endfunction

    task automatic check_outcome(input memory_game_pkg::game_status_t exp);
        assert (status == exp) else begin
            $display("Mismatch %s outcome: expected %b, actual %b", test_name, exp, status);
            mismatches++;
        end
    endtask

    task automatic start_game(input logic hard);
        level = hard;
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    // next negedge with awaiting_play high, or the end of the game
    task automatic wait_for_turn(output bit ended);
        do @(negedge clock); while (!awaiting_play && !status.done);
        ended = status.done;
    endtask

    task automatic wait_done(input int limit);
        int waited;
        waited = 0;
        while (!status.done && waited < limit) begin
            @(negedge clock);
            waited++;
        end
    endtask

    // hold for two edges, then release for two so the capture rearms
    task automatic drive_press(input memory_game_pkg::button_t code);
        buttons = code;
        repeat (2) @(negedge clock);
        buttons = '0;
        repeat (2) @(negedge clock);
    endtask

    task automatic play_game(input string name, input logic hard, input int bad_round,
                             input int bad_idx, input bit bad_multi);
        int                       rounds;
        bit                       ended;
        bit                       bad;
        memory_game_pkg::button_t code;
        test_name = name;
        rounds    = hard ? memory_game_pkg::HARD_ROUNDS : memory_game_pkg::EASY_ROUNDS;
        ended     = 1'b0;
        cur_round = 1;
        start_game(hard);
        for (int r = 1; r <= rounds && !ended; r++) begin
            cur_round = r;
            for (int k = 0; k < r && !ended; k++) begin
                wait_for_turn(ended);
                if (ended) begin
                    $display("%s: game ended before round %0d was played", name, r);
                    failures++;
                end else begin
                    repeat (take_bits(4)) @(negedge clock);
                    bad  = (r == bad_round) && (k == bad_idx);
                    code = bad ? wrong_code(seq_mem[k], bad_multi) : seq_mem[k];
                    drive_press(code);
                    if (bad) begin
                        wait_done(DONE_SLACK);
                        check_outcome(outcome(1'b0, 1'b1, 1'b0));
                        ended = 1'b1;
                    end
                end
            end
        end
        if (!ended) begin
            wait_done(DONE_SLACK);
            check_outcome(outcome(1'b1, 1'b0, 1'b0));
        end
    endtask

    task automatic run_timeout();
        bit ended;
        test_name = "timeout";
        cur_round = 1;
        start_game(1'b0);
        wait_for_turn(ended);
        if (ended) begin
            $display("%s: game ended before the first press was awaited", test_name);
            failures++;
        end
        wait_done(int'(memory_game_pkg::TIMEOUT_CYCLES) + 3);
        check_outcome(outcome(1'b0, 1'b0, 1'b1));
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int bad_round;
        int bad_idx;
        rst_n      = 1'b0;
        start      = 1'b0;
        level      = 1'b0;
        buttons    = '0;
        lfsr       = 32'ha5d8;
        mismatches = 0;
        failures   = 0;
        cycle_cnt  = 0;
        cur_round  = 0;
        shown_cnt  = 0;
        low_run    = 0;
        prev_leds  = '0;
        test_name  = "reset";
        $readmemh("sequence.hex", seq_mem);
        repeat (4) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);

        play_game("easy_win", 1'b0, 0, 0, 1'b0);
        play_game("hard_win", 1'b1, 0, 0, 1'b0);
        bad_round = 1 + take_bits(3);
        bad_idx   = take_bits(4) % bad_round;
        play_game("wrong_code", 1'b0, bad_round, bad_idx, 1'b0);
        bad_round = 1 + take_bits(3);
        bad_idx   = take_bits(4) % bad_round;
        play_game("multi_press", 1'b0, bad_round, bad_idx, 1'b1);
        run_timeout();
        repeat (2) @(negedge clock);

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- memory_game.f
hdl/memory_game_pkg.sv
hdl/play_capture.sv
hdl/sequence_rom.sv
hdl/game_controller.sv
hdl/memory_game.sv
testbench/memory_game_tb.sv

//--- Makefile
TOP = memory_game_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f memory_game.f --top-module memory_game

sim:
	verilator --binary --timing --assert -Wno-fatal -f memory_game.f \
		--top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "*** FAILED ***" >> $(LOG)
	@cat $(LOG)
	@! grep -qF '*** FAILED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sequence.hex
// one one-hot button code per line, rom address 0 first
1
4
2
8
2
1
8
4
4
2
1
8
1
2
4
8
